/* design/soc_mem_pkg.sv */
`default_nettype none

package soc_mem_pkg;

  //////////////////////////////
  // Address map
  //////////////////////////////

  // Main memory window, base plus offset mask
  localparam logic [31:0] RAM_BASE_ADDR = 32'h4000_0000;
  localparam logic [31:0] RAM_MASK_ADDR = 32'h0000_0FFF;
  localparam int          RAM_WORDS     = 1024;
  localparam int          RAM_ADDR_W    = 10;

  // 64-bit cycle timer, read as two halves
  localparam logic [31:0] TIMER_LO_ADDR = 32'h3000_0000;
  localparam logic [31:0] TIMER_HI_ADDR = 32'h3000_0004;

  //////////////////////////////
  // Latencies and rates
  //////////////////////////////

  localparam int RAM_LATENCY    = 16;
  localparam int RAM_LAT_W      = $clog2(RAM_LATENCY);
  localparam int CLKS_PER_BIT   = 16;
  localparam int BAUD_CNT_W     = $clog2(CLKS_PER_BIT);
  // Word counts above this are clamped by the loader
  localparam int LOAD_MAX_WORDS = RAM_WORDS;
  localparam int LOAD_CNT_W     = $clog2(LOAD_MAX_WORDS + 1);

  //////////////////////////////
  // Bus and port structs
  //////////////////////////////

  typedef struct packed {
    logic        valid;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } iomem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } iomem_rsp_t;

  // Word-addressed request into main memory
  typedef struct packed {
    logic                  rd_en;
    logic [3:0]            wstrb;
    logic [RAM_ADDR_W-1:0] addr;
    logic [31:0]           wdata;
  } ram_port_t;

  // Full-word write from the program loader
  typedef struct packed {
    logic                  we;
    logic [RAM_ADDR_W-1:0] addr;
    logic [31:0]           data;
  } load_wr_t;

endpackage

`default_nettype wire

/* design/iomem_fabric.sv */
`timescale 1ns/1ps
`default_nettype none

module iomem_fabric (
  input  logic                    clk_i,
  input  logic                    rst_n,
  input  soc_mem_pkg::iomem_req_t req_i,
  output soc_mem_pkg::iomem_rsp_t rsp_o,
  input  soc_mem_pkg::load_wr_t   load_wr_i,
  input  logic                    prog_mode_i,
  output soc_mem_pkg::ram_port_t  ram_o,
  input  logic [31:0]             ram_rdata_i,
  output logic                    ram_start_o,
  input  logic                    ram_ready_i
);
  import soc_mem_pkg::*;

  logic        bus_valid;
  logic        bus_write;
  logic        hit_ram;
  logic        hit_timer_lo;
  logic        hit_timer_hi;
  logic        hit_none;
  logic [63:0] cycle_cnt_q;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  // Loader owns memory in program mode, bus is ignored
  assign bus_valid = req_i.valid & ~prog_mode_i;
  assign bus_write = |req_i.wstrb;

  assign hit_ram      = bus_valid & ((req_i.addr & ~RAM_MASK_ADDR) == RAM_BASE_ADDR);
  assign hit_timer_lo = bus_valid & (req_i.addr == TIMER_LO_ADDR);
  assign hit_timer_hi = bus_valid & (req_i.addr == TIMER_HI_ADDR);
  assign hit_none     = bus_valid & ~hit_ram & ~hit_timer_lo & ~hit_timer_hi;

  // Start drops in the ready cycle so a back-to-back RAM request
  // presents a fresh rising edge to the latency timer
  assign ram_start_o = hit_ram & ~ram_ready_i;

  // Memory port mux
  always_comb begin
    if (prog_mode_i) begin
      ram_o.rd_en = 1'b0;
      ram_o.wstrb = {4{load_wr_i.we}};
      ram_o.addr  = load_wr_i.addr;
      ram_o.wdata = load_wr_i.data;
    end else begin
      ram_o.rd_en = hit_ram & ~bus_write;
      ram_o.wstrb = hit_ram ? req_i.wstrb : 4'b0000;
      ram_o.addr  = req_i.addr[RAM_ADDR_W+1:2];
      ram_o.wdata = req_i.wdata;
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  always_comb begin
    // Mapped I/O answers at once, RAM waits for the timer
    rsp_o.ready = (hit_ram & ram_ready_i) | hit_timer_lo | hit_timer_hi | hit_none;
    if (hit_timer_lo) begin
      rsp_o.rdata = cycle_cnt_q[31:0];
    end else if (hit_timer_hi) begin
      rsp_o.rdata = cycle_cnt_q[63:32];
    end else if (hit_ram) begin
      rsp_o.rdata = ram_rdata_i;
    end else begin
      rsp_o.rdata = 32'h0000_0000;
    end
  end

  // Free-running cycle timer, restarts with the system reset
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      cycle_cnt_q <= 64'd0;
    end else begin
      cycle_cnt_q <= cycle_cnt_q + 64'd1;
    end
  end

  // The timer pulse must never leak onto the bus without a request
  a_ready_needs_valid : assert property (
    @(posedge clk_i) disable iff (!rst_n) ram_ready_i |-> hit_ram
  ) else $error("RAM ready without a RAM request");

endmodule

`default_nettype wire

/* design/ram_access_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_access_timer (
  input  logic clk_i,
  input  logic rst_n,
  input  logic start_i,
  output logic ready_o
);
  import soc_mem_pkg::*;

  logic                 start_q;
  logic                 start_rise;
  logic                 busy_q;
  logic [RAM_LAT_W-1:0] cnt_q;

  assign start_rise = start_i & ~start_q;

  // Ready lands RAM_LATENCY cycles after the start edge
  assign ready_o = busy_q & (cnt_q == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      start_q <= 1'b0;
      busy_q  <= 1'b0;
      cnt_q   <= '0;
    end else begin
      start_q <= start_i;
      if (start_rise) begin
        busy_q <= 1'b1;
        cnt_q  <= RAM_LAT_W'(RAM_LATENCY - 1);
      end else if (busy_q) begin
        if (cnt_q == '0) begin
          // Pulse done, wait for the next edge
          busy_q <= 1'b0;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  a_ready_after_latency : assert property (
    @(posedge clk_i) disable iff (!rst_n) start_rise |-> ##RAM_LATENCY ready_o
  ) else $error("RAM ready not RAM_LATENCY cycles after start");

endmodule

`default_nettype wire

/* design/byte_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_ram (
  input  logic                   clk_i,
  input  soc_mem_pkg::ram_port_t port_i,
  output logic [31:0]            rdata_o
);
  import soc_mem_pkg::*;

  logic [3:0][7:0] mem_q [RAM_WORDS];
  logic [31:0]     rdata_q;

  //////////////////////////////
  // Byte-lane writes
  //////////////////////////////

  // One write column per strobe bit
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < 4; b++) begin
      if (port_i.wstrb[b]) begin
        mem_q[port_i.addr][b] <= port_i.wdata[8*b +: 8];
      end
    end
  end

  //////////////////////////////
  // Registered read
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (port_i.rd_en) begin
      rdata_q <= mem_q[port_i.addr];
    end
  end

  assign rdata_o = rdata_q;

  // Fabric decodes read and write as exclusive
  a_rd_wr_exclusive : assert property (
    @(posedge clk_i) port_i.rd_en |-> (port_i.wstrb == 4'b0000)
  ) else $error("RAM read and write in the same cycle");

endmodule

`default_nettype wire

/* design/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic       clk_i,
  input  logic       rst_n,
  input  logic       rx_i,
  output logic [7:0] byte_o,
  output logic       byte_valid_o
);
  import soc_mem_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } rx_state_t;

  rx_state_t             state_q;
  logic                  rx_meta_q;
  logic                  rx_sync_q;
  logic [BAUD_CNT_W-1:0] baud_cnt_q;
  logic [2:0]            bit_idx_q;
  logic [7:0]            shift_q;
  logic                  valid_q;
  logic                  half_bit;
  logic                  bit_end;

  assign half_bit = (baud_cnt_q == BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1));
  assign bit_end  = (baud_cnt_q == BAUD_CNT_W'(CLKS_PER_BIT - 1));

  // Two-flop synchronizer, idle line is high
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  //////////////////////////////
  // Frame FSM
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q    <= ST_IDLE;
      baud_cnt_q <= '0;
      bit_idx_q  <= 3'd0;
      valid_q    <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          baud_cnt_q <= '0;
          if (!rx_sync_q) begin
            state_q <= ST_START;
          end
        end
        ST_START: begin
          // Recheck at mid start bit to reject glitches
          if (half_bit) begin
            baud_cnt_q <= '0;
            bit_idx_q  <= 3'd0;
            state_q    <= rx_sync_q ? ST_IDLE : ST_DATA;
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        ST_DATA: begin
          if (bit_end) begin
            baud_cnt_q <= '0;
            bit_idx_q  <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= ST_STOP;
            end
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        default: begin
          // Frame with a low stop bit is dropped
          if (bit_end) begin
            valid_q <= rx_sync_q;
            state_q <= ST_IDLE;
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB first
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_DATA) && bit_end) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign byte_o       = shift_q;
  assign byte_valid_o = valid_q;

endmodule

`default_nettype wire

/* design/prog_loader_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module prog_loader_fsm (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  logic [7:0]            byte_i,
  input  logic                  byte_valid_i,
  output soc_mem_pkg::load_wr_t load_wr_o,
  output logic                  prog_mode_o,
  output logic                  sys_rst_n_o
);
  import soc_mem_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CNT_LO,
    ST_CNT_HI,
    ST_DATA,
    ST_DONE
  } load_state_t;

  load_state_t           state_q;
  logic [15:0]           count_q;
  logic [LOAD_CNT_W-1:0] count_clamped;
  logic [LOAD_CNT_W-1:0] words_left_q;
  logic [RAM_ADDR_W-1:0] addr_q;
  logic [1:0]            byte_idx_q;
  logic [31:0]           word_q;
  logic                  we_q;
  logic                  prog_mode_q;
  logic                  sys_rst_n_q;

  assign count_clamped = (count_q > 16'(LOAD_MAX_WORDS)) ? LOAD_CNT_W'(LOAD_MAX_WORDS)
                                                         : LOAD_CNT_W'(count_q);

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q      <= ST_IDLE;
      words_left_q <= '0;
      addr_q       <= '0;
      byte_idx_q   <= 2'd0;
      we_q         <= 1'b0;
      prog_mode_q  <= 1'b0;
      sys_rst_n_q  <= 1'b1;
    end else begin
      we_q <= 1'b0;
      if (we_q) begin
        addr_q <= addr_q + 1'b1;
      end
      case (state_q)
        ST_IDLE: begin
          // First byte of the stream takes over the system
          if (byte_valid_i) begin
            prog_mode_q <= 1'b1;
            sys_rst_n_q <= 1'b0;
            state_q     <= ST_CNT_LO;
          end
        end
        ST_CNT_LO: begin
          if (byte_valid_i) begin
            state_q <= ST_CNT_HI;
          end
        end
        ST_CNT_HI: begin
          words_left_q <= count_clamped;
          addr_q       <= '0;
          byte_idx_q   <= 2'd0;
          state_q      <= (count_clamped == '0) ? ST_DONE : ST_DATA;
        end
        ST_DATA: begin
          if (byte_valid_i) begin
            byte_idx_q <= byte_idx_q + 1'b1;
            if (byte_idx_q == 2'd3) begin
              we_q         <= 1'b1;
              words_left_q <= words_left_q - 1'b1;
              if (words_left_q == LOAD_CNT_W'(1)) begin
                state_q <= ST_DONE;
              end
            end
          end
        end
        default: begin
          prog_mode_q <= 1'b0;
          sys_rst_n_q <= 1'b1;
          state_q     <= ST_IDLE;
        end
      endcase
    end
  end

  // Count and word assembly, little endian
  always_ff @(posedge clk_i) begin
    if (byte_valid_i) begin
      case (state_q)
        ST_IDLE:   count_q[7:0]  <= byte_i;
        ST_CNT_LO: count_q[15:8] <= byte_i;
        ST_DATA:   word_q        <= {byte_i, word_q[31:8]};
        default: ;
      endcase
    end
  end

  assign load_wr_o.we   = we_q;
  assign load_wr_o.addr = addr_q;
  assign load_wr_o.data = word_q;
  assign prog_mode_o    = prog_mode_q;
  assign sys_rst_n_o    = sys_rst_n_q;

  a_write_in_prog_mode : assert property (
    @(posedge clk_i) disable iff (!rst_n) we_q |-> prog_mode_q
  ) else $error("loader write outside program mode");

endmodule

`default_nettype wire

/* design/mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
  input  logic                    clk_i,
  input  logic                    rst_n,
  input  soc_mem_pkg::iomem_req_t req_i,
  output soc_mem_pkg::iomem_rsp_t rsp_o,
  input  logic                    prog_rx_i,
  output logic                    prog_mode_o,
  output logic                    sys_rst_n_o
);
  import soc_mem_pkg::*;

  ram_port_t   ram_port;
  load_wr_t    load_wr;
  logic [31:0] ram_rdata;
  logic        ram_start;
  logic        ram_ready;
  logic [7:0]  rx_byte;
  logic        rx_byte_valid;
  logic        core_rst_n;

  // Board reset or loader hold
  assign core_rst_n = rst_n & sys_rst_n_o;

  iomem_fabric u_iomem_fabric (
    .clk_i       (clk_i),
    .rst_n       (core_rst_n),
    .req_i       (req_i),
    .rsp_o       (rsp_o),
    .load_wr_i   (load_wr),
    .prog_mode_i (prog_mode_o),
    .ram_o       (ram_port),
    .ram_rdata_i (ram_rdata),
    .ram_start_o (ram_start),
    .ram_ready_i (ram_ready)
  );

  ram_access_timer u_ram_access_timer (
    .clk_i   (clk_i),
    .rst_n   (core_rst_n),
    .start_i (ram_start),
    .ready_o (ram_ready)
  );

  byte_ram u_byte_ram (
    .clk_i   (clk_i),
    .port_i  (ram_port),
    .rdata_o (ram_rdata)
  );

  uart_rx u_uart_rx (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .rx_i         (prog_rx_i),
    .byte_o       (rx_byte),
    .byte_valid_o (rx_byte_valid)
  );

  prog_loader_fsm u_prog_loader_fsm (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .byte_i       (rx_byte),
    .byte_valid_i (rx_byte_valid),
    .load_wr_o    (load_wr),
    .prog_mode_o  (prog_mode_o),
    .sys_rst_n_o  (sys_rst_n_o)
  );

endmodule

`default_nettype wire

/* verification/mem_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;
  import soc_mem_pkg::*;

  localparam int          CLK_PERIOD   = 20;
  localparam logic [31:0] LFSR_SEED    = 32'h8fa8_de6e;
  localparam int          BUS_TIMEOUT  = 64;
  localparam int          LOAD_TIMEOUT = 200;
  localparam int          LOAD_WORDS   = 6;

  logic        clk_i;
  logic        rst_n;
  iomem_req_t  req;
  iomem_rsp_t  rsp_o;
  logic        prog_rx;
  logic        prog_mode_o;
  logic        sys_rst_n_o;

  logic [31:0] lfsr_q;
  logic [31:0] ref_mem [RAM_WORDS];
  logic [31:0] load_words [LOAD_WORDS];
  time         release_t;
  int          errors;
  int          checks;
  int          tests;
  int          tests_failed;

  mem_subsystem u_mem_subsystem (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .req_i       (req),
    .rsp_o       (rsp_o),
    .prog_rx_i   (prog_rx),
    .prog_mode_o (prog_mode_o),
    .sys_rst_n_o (sys_rst_n_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Loader hands the system back on this edge
  always @(posedge sys_rst_n_o) release_t = $time;

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [31:0] ram_addr(input logic [RAM_ADDR_W-1:0] idx);
    return RAM_BASE_ADDR | (32'(idx) << 2);
  endfunction

  // Strobed bytes take the new value
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic abort_run(input string reason);
    $display("Timeout: %s at %0t, no response from the DUT", reason, $time);
    $display("Test failures found");
    $finish;
  endtask

  // One request; latency counts cycles after the first valid cycle
  task automatic bus_access(input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] data, output iomem_rsp_t rsp,
                            output int latency, output time t_ready);
    int wait_cnt;
    @(negedge clk_i);
    req.valid = 1'b1;
    req.wstrb = strb;
    req.addr  = addr;
    req.wdata = data;
    wait_cnt  = 0;
    #1;
    while (rsp_o.ready !== 1'b1) begin
      if (wait_cnt == BUS_TIMEOUT) begin
        abort_run($sformatf("bus ready for address %h", addr));
      end
      @(negedge clk_i);
      #1;
      wait_cnt++;
    end
    rsp     = rsp_o;
    latency = wait_cnt;
    t_ready = $time;
    @(negedge clk_i);
    req = '0;
  endtask

  task automatic ram_write(input logic [RAM_ADDR_W-1:0] idx, input logic [3:0] strb,
                           input logic [31:0] data);
    iomem_rsp_t rsp;
    int         lat;
    time        t;
    bus_access(ram_addr(idx), strb, data, rsp, lat, t);
    ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
  endtask

  task automatic ram_read_check(input logic [RAM_ADDR_W-1:0] idx, input string what);
    iomem_rsp_t rsp;
    iomem_rsp_t exp;
    int         lat;
    time        t;
    bus_access(ram_addr(idx), 4'b0000, 32'h0, rsp, lat, t);
    exp.ready = 1'b1;
    exp.rdata = ref_mem[idx];
    check_rsp(rsp, exp, $sformatf("%s word %0d", what, idx));
  endtask

  // 8N1, LSB first, each bit CLKS_PER_BIT clocks long
  task automatic send_uart_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clk_i);
      prog_rx = frame[i];
      repeat (CLKS_PER_BIT - 1) @(negedge clk_i);
    end
  endtask

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_rsp(input iomem_rsp_t act, input iomem_rsp_t exp, input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED @%0t: %s ready %b rdata %h, expected ready %b rdata %h",
               $time, what, act.ready, act.rdata, exp.ready, exp.rdata);
    end
  endtask

  task automatic check_word(input logic [31:0] act, input logic [31:0] exp, input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED @%0t: %s got %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_latency(input int act, input int exp, input string what);
    checks++;
    if (act != exp) begin
      errors++;
      $display("CHECK FAILED @%0t: %s latency %0d, expected %0d", $time, what, act, exp);
    end
  endtask

  task automatic report_test(input string name, input int err_mark);
    tests++;
    if (errors > err_mark) begin
      tests_failed++;
      $display("[FAIL] %s: %0d mismatches", name, errors - err_mark);
    end else begin
      $display("[ok]   %s", name);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_ram_write_read();
    logic [31:0] idx [8];
    logic [31:0] data;
    int          mark;
    mark = errors;
    for (int i = 0; i < 8; i++) begin
      random_bits(RAM_ADDR_W, idx[i]);
      random_bits(32, data);
      ram_write(idx[i][RAM_ADDR_W-1:0], 4'b1111, data);
    end
    for (int i = 0; i < 8; i++) begin
      ram_read_check(idx[i][RAM_ADDR_W-1:0], "full word readback");
    end
    report_test("ram write then read", mark);
  endtask

  task automatic test_byte_strobes();
    logic [31:0] idx;
    logic [31:0] data;
    logic [31:0] strb;
    int          mark;
    mark = errors;
    for (int i = 0; i < 8; i++) begin
      random_bits(RAM_ADDR_W, idx);
      random_bits(32, data);
      ram_write(idx[RAM_ADDR_W-1:0], 4'b1111, data);
      random_bits(4, strb);
      if (strb[3:0] == 4'b0000) begin
        strb[3:0] = 4'b1000;
      end
      random_bits(32, data);
      ram_write(idx[RAM_ADDR_W-1:0], strb[3:0], data);
      ram_read_check(idx[RAM_ADDR_W-1:0], $sformatf("strobe %b", strb[3:0]));
    end
    report_test("byte strobes", mark);
  endtask

  task automatic test_ram_latency();
    iomem_rsp_t  rsp;
    logic [31:0] idx;
    logic [31:0] data;
    int          lat;
    time         t;
    int          mark;
    mark = errors;
    for (int i = 0; i < 4; i++) begin
      random_bits(RAM_ADDR_W, idx);
      random_bits(32, data);
      bus_access(ram_addr(idx[RAM_ADDR_W-1:0]), 4'b1111, data, rsp, lat, t);
      ref_mem[idx[RAM_ADDR_W-1:0]] = data;
      check_latency(lat, RAM_LATENCY, "ram write");
      bus_access(ram_addr(idx[RAM_ADDR_W-1:0]), 4'b0000, 32'h0, rsp, lat, t);
      check_latency(lat, RAM_LATENCY, "ram read");
      check_word(rsp.rdata, data, "latency read data");
    end
    report_test("ram latency", mark);
  endtask

  task automatic test_timer();
    iomem_rsp_t  rsp;
    iomem_rsp_t  exp;
    logic [31:0] v1;
    logic [31:0] gap;
    int          lat;
    time         t1;
    time         t2;
    int          mark;
    mark = errors;
    for (int i = 0; i < 3; i++) begin
      bus_access(TIMER_LO_ADDR, 4'b0000, 32'h0, rsp, lat, t1);
      check_latency(lat, 0, "timer low");
      v1 = rsp.rdata;
      random_bits(5, gap);
      repeat (gap) @(negedge clk_i);
      bus_access(TIMER_LO_ADDR, 4'b0000, 32'h0, rsp, lat, t2);
      // Counter advances once per clock
      check_word(rsp.rdata - v1, 32'((t2 - t1) / CLK_PERIOD), "timer low delta");
    end
    bus_access(TIMER_HI_ADDR, 4'b0000, 32'h0, rsp, lat, t1);
    exp.ready = 1'b1;
    exp.rdata = 32'h0;
    check_rsp(rsp, exp, "timer high");
    check_latency(lat, 0, "timer high");
    report_test("timer reads", mark);
  endtask

  task automatic test_unmapped();
    iomem_rsp_t  rsp;
    iomem_rsp_t  exp;
    logic [31:0] idx;
    logic [31:0] data;
    int          lat;
    time         t;
    int          mark;
    mark = errors;
    random_bits(RAM_ADDR_W, idx);
    random_bits(32, data);
    ram_write(idx[RAM_ADDR_W-1:0], 4'b1111, data);
    exp.ready = 1'b1;
    exp.rdata = 32'h0;
    // Same low bits as the RAM word, outside every window
    bus_access(32'h5000_0000 | (idx << 2), 4'b0000, 32'h0, rsp, lat, t);
    check_rsp(rsp, exp, "unmapped read");
    check_latency(lat, 0, "unmapped read");
    random_bits(32, data);
    bus_access(32'h5000_0000 | (idx << 2), 4'b1111, data, rsp, lat, t);
    check_latency(lat, 0, "unmapped write");
    ram_read_check(idx[RAM_ADDR_W-1:0], "after unmapped write");
    report_test("unmapped addresses", mark);
  endtask

  task automatic test_program_load();
    iomem_rsp_t rsp;
    int         lat;
    int         wait_cnt;
    time        t;
    longint     elapsed;
    int         mark;
    mark = errors;
    for (int i = 0; i < LOAD_WORDS; i++) begin
      random_bits(32, load_words[i]);
    end
    send_uart_byte(8'(LOAD_WORDS));
    // Bits are prog_mode, sys_rst_n
    check_word({30'd0, prog_mode_o, sys_rst_n_o}, 32'd2, "mode during load");
    send_uart_byte(8'(LOAD_WORDS >> 8));
    for (int w = 0; w < LOAD_WORDS; w++) begin
      for (int b = 0; b < 4; b++) begin
        send_uart_byte(load_words[w][8*b +: 8]);
      end
      ref_mem[w] = load_words[w];
    end
    wait_cnt = 0;
    while (prog_mode_o !== 1'b0) begin
      if (wait_cnt == LOAD_TIMEOUT) begin
        abort_run("end of program load");
      end
      @(negedge clk_i);
      wait_cnt++;
    end
    check_word({30'd0, prog_mode_o, sys_rst_n_o}, 32'd1, "mode after load");
    bus_access(TIMER_LO_ADDR, 4'b0000, 32'h0, rsp, lat, t);
    elapsed = (t - release_t) / CLK_PERIOD;
    checks++;
    if (rsp.rdata >= elapsed + 1) begin
      errors++;
      $display("CHECK FAILED @%0t: timer after load read %0d, expected below %0d",
               $time, rsp.rdata, elapsed + 1);
    end
    for (int w = 0; w < LOAD_WORDS; w++) begin
      ram_read_check(w[RAM_ADDR_W-1:0], "loaded");
    end
    report_test("serial program load", mark);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    clk_i        = 1'b0;
    rst_n        = 1'b0;
    req          = '0;
    prog_rx      = 1'b1;
    lfsr_q       = LFSR_SEED;
    release_t    = 0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    tests_failed = 0;
    repeat (10) @(negedge clk_i);
    rst_n = 1'b1;
    repeat (2) @(negedge clk_i);

    test_ram_write_read();
    test_byte_strobes();
    test_ram_latency();
    test_timer();
    test_unmapped();
    test_program_load();

    $display("Tests: %0d run, %0d failed; checks: %0d run, %0d failed",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mem_subsystem.f */
design/soc_mem_pkg.sv
design/iomem_fabric.sv
design/ram_access_timer.sv
design/byte_ram.sv
design/uart_rx.sv
design/prog_loader_fsm.sv
design/mem_subsystem.sv
verification/mem_subsystem_tb.sv
